// File: sources.f
cpu_pkg.sv
instr_buffer.sv
decoder.sv
regfile.sv
dispatch.sv
execute.sv
cpu_top.sv
cpu_properties.sv
tb_cpu_top.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f sources.f --top-module tb_cpu_top -o sim_cpu_top; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_cpu_top)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// File: tb_cpu_top.sv
`default_nettype none

module tb_cpu_top import cpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_rows    = 20;
    localparam int cycle_limit = 4 * num_rows + 50;

    // Major opcodes of the tested LoongArch subset
    localparam logic [16:0] opc_add_w   = 17'h00020;
    localparam logic [16:0] opc_sub_w   = 17'h00022;
    localparam logic [16:0] opc_and     = 17'h00029;
    localparam logic [16:0] opc_or      = 17'h0002a;
    localparam logic [16:0] opc_xor     = 17'h0002b;
    localparam logic [9:0]  opc_addi_w  = 10'h00a;
    localparam logic [6:0]  opc_lu12i_w = 7'h0a;

    typedef struct packed {
        logic [31:0] instr;
        logic        wen;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } prog_row_t;

    logic                          clk;
    logic                          reset;
    fetch_slot_t [fetch_width-1:0] fetch;
    logic                          fetch_ready;
    logic                          wb_valid;
    logic [31:0]                   wb_pc;
    logic                          wb_wen;
    logic [4:0]                    wb_wnum;
    logic [31:0]                   wb_wdata;

    prog_row_t prog [num_rows];
    int        errors;
    int        commit_idx;
    int        cycles;
    logic      checking;
    logic      saw_ready_low;
    logic      saw_ready_rise;

    cpu_top #(
        .ib_depth (4)
    ) dut (
        .clk                 (clk),
        .reset_i             (reset),
        .fetch_i             (fetch),
        .fetch_ready_o       (fetch_ready),
        .debug_wb_valid_o    (wb_valid),
        .debug_wb_pc_o       (wb_pc),
        .debug_wb_rf_wen_o   (wb_wen),
        .debug_wb_rf_wnum_o  (wb_wnum),
        .debug_wb_rf_wdata_o (wb_wdata)
    );

    function automatic logic [31:0] encode_3r(logic [16:0] opc, int rk, int rj, int rd);
        return {opc, 5'(rk), 5'(rj), 5'(rd)};
    endfunction

    function automatic logic [31:0] encode_2ri12(logic [9:0] opc, logic [11:0] imm,
                                                 int rj, int rd);
        return {opc, imm, 5'(rj), 5'(rd)};
    endfunction

    function automatic logic [31:0] encode_1ri20(logic [6:0] opc, logic [19:0] imm, int rd);
        return {opc, imm, 5'(rd)};
    endfunction

    function automatic prog_row_t make_row(logic [31:0] instr, logic wen, int wnum,
                                           logic [31:0] wdata);
        prog_row_t row;
        row.instr = instr;
        row.wen   = wen;
        row.wnum  = 5'(wnum);
        row.wdata = wdata;
        return row;
    endfunction

    function automatic fetch_slot_t make_slot(int idx, logic valid);
        fetch_slot_t slot;
        slot = '0;
        if (valid) begin
            slot.valid = 1'b1;
            slot.pc    = 32'(idx * 4);
            slot.instr = prog[idx].instr;
        end
        return slot;
    endfunction

    // Expected results worked out by hand from the ALU rules
    task automatic load_program();
        prog[0]  = make_row(encode_1ri20(opc_lu12i_w, 20'h12345, 1), 1, 1, 32'h12345000);
        prog[1]  = make_row(encode_2ri12(opc_addi_w, 12'h678, 1, 1), 1, 1, 32'h12345678);
        prog[2]  = make_row(encode_2ri12(opc_addi_w, 12'hfff, 0, 2), 1, 2, 32'hffffffff);
        prog[3]  = make_row(encode_3r(opc_add_w, 2, 1, 3), 1, 3, 32'h12345677);
        prog[4]  = make_row(encode_3r(opc_sub_w, 1, 3, 4), 1, 4, 32'hffffffff);
        prog[5]  = make_row(encode_3r(opc_and, 4, 1, 5), 1, 5, 32'h12345678);
        prog[6]  = make_row(encode_3r(opc_or, 3, 1, 6), 1, 6, 32'h1234567f);
        prog[7]  = make_row(encode_3r(opc_xor, 1, 6, 7), 1, 7, 32'h00000007);
        // Write to r0 is dropped, then r0 is read back
        prog[8]  = make_row(encode_2ri12(opc_addi_w, 12'h005, 1, 0), 0, 0, 32'h0);
        prog[9]  = make_row(encode_3r(opc_add_w, 1, 0, 8), 1, 8, 32'h12345678);
        // Unknown word, rd field is 31
        prog[10] = make_row(32'hffffffff, 0, 31, 32'h0);
        prog[11] = make_row(encode_2ri12(opc_addi_w, 12'hff8, 7, 9), 1, 9, 32'hffffffff);
        prog[12] = make_row(encode_1ri20(opc_lu12i_w, 20'hfffff, 10), 1, 10, 32'hfffff000);
        prog[13] = make_row(encode_2ri12(opc_addi_w, 12'h7ff, 10, 10), 1, 10, 32'hfffff7ff);
        prog[14] = make_row(encode_3r(opc_sub_w, 10, 0, 11), 1, 11, 32'h00000801);
        prog[15] = make_row(encode_3r(opc_xor, 10, 11, 12), 1, 12, 32'hfffffffe);
        prog[16] = make_row(encode_3r(opc_and, 9, 12, 13), 1, 13, 32'hfffffffe);
        prog[17] = make_row(encode_3r(opc_add_w, 11, 13, 14), 1, 14, 32'h000007ff);
        prog[18] = make_row(encode_3r(opc_or, 14, 2, 15), 1, 15, 32'hffffffff);
        prog[19] = make_row(encode_3r(opc_add_w, 5, 8, 16), 1, 16, 32'h2468acf0);
    endtask

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    // Slot 1 only when a random draw allows it and a row remains
    task automatic offer_pair(int idx);
        fetch_slot_t [fetch_width-1:0] pair;
        logic                          second;
        second  = (idx + 1 < num_rows) && ($urandom % 4 != 0);
        pair[0] = make_slot(idx, idx < num_rows);
        pair[1] = make_slot(idx + 1, second);
        fetch <= pair;
    endtask

    task automatic feed_program();
        int idx;
        int taken;
        idx = 0;
        @(posedge clk);
        offer_pair(idx);
        while (idx < num_rows) begin
            @(negedge clk);
            taken = 0;
            if (fetch_ready && fetch[0].valid) begin
                taken = fetch[1].valid ? 2 : 1;
            end
            @(posedge clk);
            if (taken != 0) begin
                idx += taken;
                offer_pair(idx);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("test failed");
        $finish;
    end

    // Commit checker, in program order
    always @(negedge clk) begin
        if (checking) begin
            if (!fetch_ready) begin
                saw_ready_low = 1'b1;
            end else if (saw_ready_low) begin
                saw_ready_rise = 1'b1;
            end
            if (wb_valid) begin
                if (commit_idx >= num_rows) begin
                    $display("Unexpected commit at pc %h after the last program row", wb_pc);
                    errors++;
                end else begin
                    check_value("debug_wb_pc_o", wb_pc, 32'(commit_idx * 4));
                    check_value("debug_wb_rf_wen_o", 32'(wb_wen), 32'(prog[commit_idx].wen));
                    check_value("debug_wb_rf_wnum_o", 32'(wb_wnum),
                                32'(prog[commit_idx].wnum));
                    if (prog[commit_idx].wen) begin
                        check_value("debug_wb_rf_wdata_o", wb_wdata, prog[commit_idx].wdata);
                    end
                end
                commit_idx++;
            end
        end
    end

    initial begin
        void'($urandom(74074));
        errors         = 0;
        commit_idx     = 0;
        checking       = 1'b0;
        saw_ready_low  = 1'b0;
        saw_ready_rise = 1'b0;
        reset <= 1'b1;
        fetch <= '0;
        load_program();
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // Idle pipeline with no feed
        repeat (5) begin
            @(negedge clk);
            check_value("debug_wb_valid_o", 32'(wb_valid), 32'd0);
            check_value("fetch_ready_o", 32'(fetch_ready), 32'd1);
        end

        checking = 1'b1;
        feed_program();
        wait (commit_idx >= num_rows);
        // Extra cycles catch duplicated commits
        repeat (8) @(negedge clk);

        if (!saw_ready_low || !saw_ready_rise) begin
            $display("fetch_ready_o did not drop and recover under a continuous feed");
            errors++;
        end
        $display("%0d errors, %0d of %0d commits seen", errors, commit_idx, num_rows);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cpu_properties.sv
`default_nettype none

module cpu_properties import cpu_pkg::*; (
    input logic                          clk,
    input logic                          reset_i,
    input fetch_slot_t [fetch_width-1:0] fetch_i,
    input logic                          fetch_ready_i,
    input logic                          wb_valid_i,
    input logic                          wb_rf_wen_i,
    input logic [reg_addr_w-1:0]         wb_rf_wnum_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // Buffer leaves reset empty
    ready_after_reset: assert property (@(posedge clk) $fell(reset_i) |-> fetch_ready_i)
        else $error("fetch_ready_o low in the first cycle after reset");

    slot_order: assert property (@(posedge clk) disable iff (reset_i)
        !(fetch_i[1].valid && !fetch_i[0].valid))
        else $error("fetch slot 1 valid while slot 0 is empty");

    wen_needs_valid: assert property (@(posedge clk) disable iff (reset_i)
        wb_rf_wen_i |-> wb_valid_i)
        else $error("commit write enable without a valid commit");

    // r0 writes never reach the commit port
    no_r0_write: assert property (@(posedge clk) disable iff (reset_i)
        wb_rf_wen_i |-> wb_rf_wnum_i != '0)
        else $error("commit writes register zero");

endmodule

bind cpu_top cpu_properties u_cpu_properties (
    .clk           (clk),
    .reset_i       (reset_i),
    .fetch_i       (fetch_i),
    .fetch_ready_i (fetch_ready_o),
    .wb_valid_i    (debug_wb_valid_o),
    .wb_rf_wen_i   (debug_wb_rf_wen_o),
    .wb_rf_wnum_i  (debug_wb_rf_wnum_o)
);

`default_nettype wire

// File: cpu_top.sv
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter int ib_depth = 4
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  fetch_slot_t [fetch_width-1:0] fetch_i,
    output logic                          fetch_ready_o,
    output logic                          debug_wb_valid_o,
    output logic [xlen-1:0]               debug_wb_pc_o,
    output logic                          debug_wb_rf_wen_o,
    output logic [reg_addr_w-1:0]         debug_wb_rf_wnum_o,
    output logic [xlen-1:0]               debug_wb_rf_wdata_o
);

    fetch_slot_t           ib_head;
    decoded_instr_t        dec;
    issue_t                issue;
    wb_t                   ex_fwd;
    wb_t                   wb;
    logic [reg_addr_w-1:0] rf_raddr_a;
    logic [reg_addr_w-1:0] rf_raddr_b;
    logic [xlen-1:0]       rf_rdata_a;
    logic [xlen-1:0]       rf_rdata_b;

    instr_buffer #(
        .depth       (ib_depth),
        .fetch_width (fetch_width)
    ) u_instr_buffer (
        .clk           (clk),
        .reset_i       (reset_i),
        .fetch_i       (fetch_i),
        .fetch_ready_o (fetch_ready_o),
        .head_o        (ib_head)
    );

    decoder u_decoder (
        .slot_i (ib_head),
        .dec_o  (dec)
    );

    dispatch u_dispatch (
        .clk          (clk),
        .reset_i      (reset_i),
        .dec_i        (dec),
        .ex_fwd_i     (ex_fwd),
        .wb_fwd_i     (wb),
        .rf_raddr_a_o (rf_raddr_a),
        .rf_raddr_b_o (rf_raddr_b),
        .rf_rdata_a_i (rf_rdata_a),
        .rf_rdata_b_i (rf_rdata_b),
        .issue_o      (issue)
    );

    execute u_execute (
        .clk      (clk),
        .reset_i  (reset_i),
        .issue_i  (issue),
        .ex_fwd_o (ex_fwd),
        .wb_o     (wb)
    );

    regfile u_regfile (
        .clk       (clk),
        .reset_i   (reset_i),
        .wb_i      (wb),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b)
    );

    // Commit port mirrors the writeback register
    assign debug_wb_valid_o    = wb.valid;
    assign debug_wb_pc_o       = wb.pc;
    assign debug_wb_rf_wen_o   = wb.rf_we;
    assign debug_wb_rf_wnum_o  = wb.rd;
    assign debug_wb_rf_wdata_o = wb.wdata;

endmodule

`default_nettype wire

// File: execute.sv
`default_nettype none

module execute import cpu_pkg::*; (
    input  logic   clk,
    input  logic   reset_i,
    input  issue_t issue_i,
    output wb_t    ex_fwd_o,
    output wb_t    wb_o
);

    logic [xlen-1:0] alu_res;

    always_comb begin
        case (issue_i.alu_op)
            alu_add: alu_res = issue_i.src_a + issue_i.src_b;
            alu_sub: alu_res = issue_i.src_a - issue_i.src_b;
            alu_and: alu_res = issue_i.src_a & issue_i.src_b;
            alu_or:  alu_res = issue_i.src_a | issue_i.src_b;
            alu_xor: alu_res = issue_i.src_a ^ issue_i.src_b;
            // Upper immediate already shifted by the decoder
            alu_lui: alu_res = issue_i.src_b;
            default: alu_res = '0;
        endcase
    end

    // Same-cycle result for dispatch forwarding
    always_comb begin
        ex_fwd_o.valid = issue_i.valid;
        ex_fwd_o.pc    = issue_i.pc;
        ex_fwd_o.rf_we = issue_i.valid && issue_i.rf_we;
        ex_fwd_o.rd    = issue_i.rd;
        ex_fwd_o.wdata = alu_res;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_o.valid <= 1'b0;
            wb_o.rf_we <= 1'b0;
        end else begin
            wb_o.valid <= ex_fwd_o.valid;
            wb_o.rf_we <= ex_fwd_o.rf_we;
        end
        wb_o.pc    <= ex_fwd_o.pc;
        wb_o.rd    <= ex_fwd_o.rd;
        wb_o.wdata <= ex_fwd_o.wdata;
    end

endmodule

`default_nettype wire

// File: dispatch.sv
`default_nettype none

module dispatch import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  decoded_instr_t        dec_i,
    input  wb_t                   ex_fwd_i,
    input  wb_t                   wb_fwd_i,
    output logic [reg_addr_w-1:0] rf_raddr_a_o,
    output logic [reg_addr_w-1:0] rf_raddr_b_o,
    input  logic [xlen-1:0]       rf_rdata_a_i,
    input  logic [xlen-1:0]       rf_rdata_b_i,
    output issue_t                issue_o
);

    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] rk_val;

    // Youngest producer wins: execute, then writeback, then the register file
    function automatic logic [xlen-1:0] fwd_sel(
        input logic [reg_addr_w-1:0] addr,
        input logic [xlen-1:0]       rf_data,
        input wb_t                   ex_fwd,
        input wb_t                   wb_fwd
    );
        logic [xlen-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (ex_fwd.valid && ex_fwd.rf_we && ex_fwd.rd == addr) begin
            val = ex_fwd.wdata;
        end else if (wb_fwd.valid && wb_fwd.rf_we && wb_fwd.rd == addr) begin
            val = wb_fwd.wdata;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign rf_raddr_a_o = dec_i.rj;
    assign rf_raddr_b_o = dec_i.rk;

    always_comb begin
        src_a  = fwd_sel(dec_i.rj, rf_rdata_a_i, ex_fwd_i, wb_fwd_i);
        rk_val = fwd_sel(dec_i.rk, rf_rdata_b_i, ex_fwd_i, wb_fwd_i);
        src_b  = dec_i.use_imm ? dec_i.imm : rk_val;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            issue_o.valid <= 1'b0;
        end else begin
            issue_o.valid <= dec_i.valid;
        end
        issue_o.pc     <= dec_i.pc;
        issue_o.alu_op <= dec_i.alu_op;
        issue_o.rd     <= dec_i.rd;
        issue_o.rf_we  <= dec_i.rf_we;
        issue_o.src_a  <= src_a;
        issue_o.src_b  <= src_b;
    end

endmodule

`default_nettype wire

// File: regfile.sv
`default_nettype none

module regfile import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  wb_t                   wb_i,
    input  logic [reg_addr_w-1:0] raddr_a_i,
    input  logic [reg_addr_w-1:0] raddr_b_i,
    output logic [xlen-1:0]       rdata_a_o,
    output logic [xlen-1:0]       rdata_b_o
);

    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid && wb_i.rf_we && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.wdata;
        end
    end

    // r0 is hardwired to zero
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

// File: decoder.sv
`default_nettype none

module decoder import cpu_pkg::*; (
    input  fetch_slot_t    slot_i,
    output decoded_instr_t dec_o
);

    instr_word_u word;
    logic        known;

    assign word = slot_i.instr;

    always_comb begin
        known         = 1'b1;
        dec_o.valid   = slot_i.valid;
        dec_o.pc      = slot_i.pc;
        dec_o.alu_op  = alu_add;
        // rd and rj sit in the same bits in every layout that has them
        dec_o.rd      = word.r3.rd;
        dec_o.rj      = word.r3.rj;
        dec_o.rk      = word.r3.rk;
        dec_o.imm     = '0;
        dec_o.use_imm = 1'b0;

        if (word.r3.opcode == op_add_w) begin
            dec_o.alu_op = alu_add;
        end else if (word.r3.opcode == op_sub_w) begin
            dec_o.alu_op = alu_sub;
        end else if (word.r3.opcode == op_and) begin
            dec_o.alu_op = alu_and;
        end else if (word.r3.opcode == op_or) begin
            dec_o.alu_op = alu_or;
        end else if (word.r3.opcode == op_xor) begin
            dec_o.alu_op = alu_xor;
        end else if (word.ri12.opcode == op_addi_w) begin
            dec_o.alu_op  = alu_add;
            dec_o.rk      = '0;
            dec_o.imm     = {{(xlen - 12){word.ri12.imm[11]}}, word.ri12.imm};
            dec_o.use_imm = 1'b1;
        end else if (word.ri20.opcode == op_lu12i_w) begin
            // Immediate lands in the upper 20 bits
            dec_o.alu_op  = alu_lui;
            dec_o.rj      = '0;
            dec_o.rk      = '0;
            dec_o.imm     = {word.ri20.imm, 12'b0};
            dec_o.use_imm = 1'b1;
        end else begin
            known = 1'b0;
        end

        // Unknown words still commit, without a register write
        dec_o.rf_we = known && (dec_o.rd != '0);
    end

endmodule

`default_nettype wire

// File: instr_buffer.sv
`default_nettype none

module instr_buffer import cpu_pkg::*; #(
    parameter int depth       = 4,
    parameter int fetch_width = cpu_pkg::fetch_width
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  fetch_slot_t [fetch_width-1:0] fetch_i,
    output logic                          fetch_ready_o,
    output fetch_slot_t                   head_o
);

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    fetch_slot_t      mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] push_cnt;
    logic             accept;
    logic             pop;

    // Room for a full pair, independent of the offered slots
    assign fetch_ready_o = (cnt_w'(depth) - count) >= cnt_w'(fetch_width);
    assign accept        = fetch_ready_o && fetch_i[0].valid;
    // Backend drains one entry whenever one is present
    assign pop           = count != '0;

    // Valid slots are contiguous from slot 0
    always_comb begin
        push_cnt = '0;
        for (int i = 0; i < fetch_width; i++) begin
            if (accept && fetch_i[i].valid) begin
                push_cnt = push_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < fetch_width; i++) begin
            if (accept && fetch_i[i].valid) begin
                mem[wr_ptr + ptr_w'(i)] <= fetch_i[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + ptr_w'(push_cnt);
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + push_cnt - cnt_w'(pop);
        end
    end

    always_comb begin
        head_o       = mem[rd_ptr];
        head_o.valid = pop;
    end

endmodule

`default_nettype wire

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int xlen        = 32;
    localparam int reg_count   = 32;
    localparam int reg_addr_w  = 5;
    localparam int fetch_width = 2;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_lui = 3'd5
    } alu_op_e;

    // One instruction word seen through the three field layouts
    typedef union packed {
        struct packed {
            logic [16:0]           opcode;
            logic [reg_addr_w-1:0] rk;
            logic [reg_addr_w-1:0] rj;
            logic [reg_addr_w-1:0] rd;
        } r3;
        struct packed {
            logic [9:0]            opcode;
            logic [11:0]           imm;
            logic [reg_addr_w-1:0] rj;
            logic [reg_addr_w-1:0] rd;
        } ri12;
        struct packed {
            logic [6:0]            opcode;
            logic [19:0]           imm;
            logic [reg_addr_w-1:0] rd;
        } ri20;
    } instr_word_u;

    // 3R opcodes, bits 31:15
    localparam logic [16:0] op_add_w   = 17'h00020;
    localparam logic [16:0] op_sub_w   = 17'h00022;
    localparam logic [16:0] op_and     = 17'h00029;
    localparam logic [16:0] op_or      = 17'h0002a;
    localparam logic [16:0] op_xor     = 17'h0002b;
    // 2RI12 opcode, bits 31:22
    localparam logic [9:0]  op_addi_w  = 10'h00a;
    // 1RI20 opcode, bits 31:25
    localparam logic [6:0]  op_lu12i_w = 7'h0a;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        instr_word_u     instr;
    } fetch_slot_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        alu_op_e               alu_op;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rj;
        logic [reg_addr_w-1:0] rk;
        logic [xlen-1:0]       imm;
        logic                  use_imm;
        logic                  rf_we;
    } decoded_instr_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        alu_op_e               alu_op;
        logic [reg_addr_w-1:0] rd;
        logic                  rf_we;
        logic [xlen-1:0]       src_a;
        logic [xlen-1:0]       src_b;
    } issue_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic                  rf_we;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       wdata;
    } wb_t;

endpackage

`default_nettype wire
